// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // data path and instruction width
    localparam int xlen = 32;

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;

    // funct3 codes
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_sr  = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 codes, alt selects SUB and SRA
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // alu operations chosen in decode
    localparam int alu_op_width = 4;
    localparam logic [alu_op_width-1:0] alu_add    = 4'd0;
    localparam logic [alu_op_width-1:0] alu_sub    = 4'd1;
    localparam logic [alu_op_width-1:0] alu_sll    = 4'd2;
    localparam logic [alu_op_width-1:0] alu_slt    = 4'd3;
    localparam logic [alu_op_width-1:0] alu_xor    = 4'd4;
    localparam logic [alu_op_width-1:0] alu_srl    = 4'd5;
    localparam logic [alu_op_width-1:0] alu_sra    = 4'd6;
    localparam logic [alu_op_width-1:0] alu_or     = 4'd7;
    localparam logic [alu_op_width-1:0] alu_and    = 4'd8;
    localparam logic [alu_op_width-1:0] alu_pass_b = 4'd9;

endpackage

`default_nettype wire

// File: source/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    // on-chip instruction memory, in 32-bit words
    localparam int imem_words      = 1024;
    localparam int imem_addr_width = $clog2(imem_words);

    // integer register file
    localparam int reg_count      = 32;
    localparam int reg_addr_width = $clog2(reg_count);

endpackage

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import rv_isa_pkg::*, core_cfg_pkg::*;
(
    input  logic                       clock_1hz,
    input  logic                       KEY0,
    input  logic                       prog_we,
    input  logic [imem_addr_width-1:0] prog_addr,
    input  logic [xlen-1:0]            prog_data,
    output logic                       if_valid,
    output logic [xlen-1:0]            if_instr,
    output logic [xlen-1:0]            if_pc,
    output logic                       LEDR0
);

    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] raw_word;

    // load port, also active while the core is held in reset
    always_ff @(posedge clock_1hz) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // word index from the byte pc
    assign raw_word = imem[pc[imem_addr_width+1:2]];

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            pc       <= '0;
            if_valid <= 1'b0;
            LEDR0    <= 1'b0;
        end else begin
            pc       <= pc + xlen'(4);
            if_valid <= 1'b1;
            // heartbeat
            LEDR0    <= ~LEDR0;
        end
    end

    // memory holds words big-endian, the core wants them little-endian
    always_ff @(posedge clock_1hz) begin
        if_instr <= {raw_word[7:0], raw_word[15:8], raw_word[23:16], raw_word[31:24]};
        if_pc    <= pc;
    end

    pc_aligned: assert property (
        @(posedge clock_1hz) disable iff (!KEY0)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*, core_cfg_pkg::*;
(
    input  logic                      clock_1hz,
    input  logic                      KEY0,
    input  logic                      if_valid,
    input  logic [xlen-1:0]           if_instr,
    input  logic [xlen-1:0]           if_pc,
    output logic [reg_addr_width-1:0] rs1_addr,
    output logic [reg_addr_width-1:0] rs2_addr,
    input  logic [xlen-1:0]           rs1_data,
    input  logic [xlen-1:0]           rs2_data,
    input  logic                      ex_fwd_valid,
    input  logic [reg_addr_width-1:0] ex_fwd_rd,
    input  logic [xlen-1:0]           ex_fwd_data,
    output logic                      id_valid,
    output logic [alu_op_width-1:0]   id_alu_op,
    output logic [reg_addr_width-1:0] id_rd,
    output logic [xlen-1:0]           id_op_a,
    output logic [xlen-1:0]           id_op_b,
    output logic                      id_illegal
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [xlen-1:0]         imm_i;
    logic [xlen-1:0]         imm_u;
    logic [xlen-1:0]         rs1_val;
    logic [xlen-1:0]         rs2_val;
    logic [alu_op_width-1:0] alu_op;
    logic [xlen-1:0]         op_a;
    logic [xlen-1:0]         op_b;
    logic                    illegal;

    assign opcode   = if_instr[6:0];
    assign funct3   = if_instr[14:12];
    assign funct7   = if_instr[31:25];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    assign imm_i = {{(xlen-12){if_instr[31]}}, if_instr[31:20]};
    assign imm_u = {if_instr[31:12], 12'b0};

    // result of the instruction one ahead wins over the register file
    assign rs1_val = (rs1_addr != '0 && ex_fwd_valid && ex_fwd_rd == rs1_addr) ?
                     ex_fwd_data : rs1_data;
    assign rs2_val = (rs2_addr != '0 && ex_fwd_valid && ex_fwd_rd == rs2_addr) ?
                     ex_fwd_data : rs2_data;

    always_comb begin
        alu_op  = alu_add;
        illegal = 1'b0;
        op_a    = rs1_val;
        op_b    = imm_i;
        case (opcode)
            op_lui: begin
                alu_op = alu_pass_b;
                op_a   = '0;
                op_b   = imm_u;
            end
            op_auipc: begin
                op_a = if_pc;
                op_b = imm_u;
            end
            op_op_imm: begin
                // immediate shifts and SLTIU are outside the subset
                case (funct3)
                    f3_add:  alu_op = alu_add;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: illegal = 1'b1;
                endcase
            end
            op_op: begin
                op_b    = rs2_val;
                illegal = (funct7 != f7_base);
                case (funct3)
                    f3_add: begin
                        alu_op  = (funct7 == f7_alt) ? alu_sub : alu_add;
                        illegal = (funct7 != f7_base) && (funct7 != f7_alt);
                    end
                    f3_sr: begin
                        alu_op  = (funct7 == f7_alt) ? alu_sra : alu_srl;
                        illegal = (funct7 != f7_base) && (funct7 != f7_alt);
                    end
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            id_valid   <= 1'b0;
            id_illegal <= 1'b0;
        end else begin
            id_valid   <= if_valid;
            id_illegal <= if_valid && illegal;
        end
    end

    always_ff @(posedge clock_1hz) begin
        id_alu_op <= alu_op;
        id_rd     <= if_instr[11:7];
        id_op_a   <= op_a;
        id_op_b   <= op_b;
    end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import rv_isa_pkg::*, core_cfg_pkg::*;
(
    input  logic                      clock_1hz,
    input  logic                      KEY0,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    output logic [xlen-1:0]           rs1_data,
    output logic [xlen-1:0]           rs2_data,
    input  logic                      wb_valid,
    input  logic [reg_addr_width-1:0] wb_rd,
    input  logic [xlen-1:0]           wb_data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:reg_count-1];

    always_ff @(posedge clock_1hz) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through so decode sees the value still in the writeback register
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wb_valid && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wb_valid && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

    // execute must filter x0 destinations before they reach this port
    no_x0_write: assert property (
        @(posedge clock_1hz) disable iff (!KEY0)
        wb_valid |-> wb_rd != '0
    );

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import rv_isa_pkg::*, core_cfg_pkg::*;
(
    input  logic                      clock_1hz,
    input  logic                      KEY0,
    input  logic                      id_valid,
    input  logic [alu_op_width-1:0]   id_alu_op,
    input  logic [reg_addr_width-1:0] id_rd,
    input  logic [xlen-1:0]           id_op_a,
    input  logic [xlen-1:0]           id_op_b,
    input  logic                      id_illegal,
    output logic                      ex_fwd_valid,
    output logic [reg_addr_width-1:0] ex_fwd_rd,
    output logic [xlen-1:0]           ex_fwd_data,
    output logic                      wb_valid,
    output logic [reg_addr_width-1:0] wb_rd,
    output logic [xlen-1:0]           wb_data,
    output logic [7:0]                LEDG,
    output logic                      LEDR9
);

    logic [xlen-1:0] result;
    logic [4:0]      shamt;

    assign shamt = id_op_b[4:0];

    always_comb begin
        case (id_alu_op)
            alu_add:    result = id_op_a + id_op_b;
            alu_sub:    result = id_op_a - id_op_b;
            alu_sll:    result = id_op_a << shamt;
            alu_slt:    result = xlen'($signed(id_op_a) < $signed(id_op_b));
            alu_xor:    result = id_op_a ^ id_op_b;
            alu_srl:    result = id_op_a >> shamt;
            alu_sra:    result = $unsigned($signed(id_op_a) >>> shamt);
            alu_or:     result = id_op_a | id_op_b;
            alu_and:    result = id_op_a & id_op_b;
            alu_pass_b: result = id_op_b;
            default:    result = '0;
        endcase
    end

    // only legal results with a real destination are forwarded or written
    assign ex_fwd_valid = id_valid && !id_illegal && (id_rd != '0);
    assign ex_fwd_rd    = id_rd;
    assign ex_fwd_data  = result;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            wb_valid <= 1'b0;
            LEDG     <= '0;
            LEDR9    <= 1'b0;
        end else begin
            wb_valid <= ex_fwd_valid;
            if (ex_fwd_valid) begin
                LEDG <= result[7:0];
            end
            // trap light stays on until reset
            if (id_valid && id_illegal) begin
                LEDR9 <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_1hz) begin
        wb_rd   <= id_rd;
        wb_data <= result;
    end

    wb_rd_nonzero: assert property (
        @(posedge clock_1hz) disable iff (!KEY0)
        wb_valid |-> wb_rd != '0
    );

endmodule

`default_nettype wire

// File: source/cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board
    import rv_isa_pkg::*, core_cfg_pkg::*;
(
    input  logic                       clock_1hz,
    input  logic                       KEY0,
    input  logic                       prog_we,
    input  logic [imem_addr_width-1:0] prog_addr,
    input  logic [xlen-1:0]            prog_data,
    output logic [7:0]                 LEDG,
    output logic                       LEDR0,
    output logic                       LEDR9,
    output logic                       wb_valid,
    output logic [reg_addr_width-1:0]  wb_rd,
    output logic [xlen-1:0]            wb_data
);

    logic                      if_valid;
    logic [xlen-1:0]           if_instr;
    logic [xlen-1:0]           if_pc;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic                      ex_fwd_valid;
    logic [reg_addr_width-1:0] ex_fwd_rd;
    logic [xlen-1:0]           ex_fwd_data;
    logic                      id_valid;
    logic [alu_op_width-1:0]   id_alu_op;
    logic [reg_addr_width-1:0] id_rd;
    logic [xlen-1:0]           id_op_a;
    logic [xlen-1:0]           id_op_b;
    logic                      id_illegal;

    fetch_stage fetch0 (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .if_valid  (if_valid),
        .if_instr  (if_instr),
        .if_pc     (if_pc),
        .LEDR0     (LEDR0)
    );

    decode_stage decode0 (
        .clock_1hz    (clock_1hz),
        .KEY0         (KEY0),
        .if_valid     (if_valid),
        .if_instr     (if_instr),
        .if_pc        (if_pc),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .id_valid     (id_valid),
        .id_alu_op    (id_alu_op),
        .id_rd        (id_rd),
        .id_op_a      (id_op_a),
        .id_op_b      (id_op_b),
        .id_illegal   (id_illegal)
    );

    register_file regs0 (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    execute_stage execute0 (
        .clock_1hz    (clock_1hz),
        .KEY0         (KEY0),
        .id_valid     (id_valid),
        .id_alu_op    (id_alu_op),
        .id_rd        (id_rd),
        .id_op_a      (id_op_a),
        .id_op_b      (id_op_b),
        .id_illegal   (id_illegal),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .LEDG         (LEDG),
        .LEDR9        (LEDR9)
    );

endmodule

`default_nettype wire

// File: test/cpu_tb_program.svh
`ifndef cpu_tb_program_svh
`define cpu_tb_program_svh

// columns are test name, mnemonic, rd, rs1, rs2 and a forced negative immediate
task automatic build_table();
    add_row("lui_neg", "lui", 1, 0, 0, 1'b1);
    add_row("lui_pos", "lui", 2, 0, 0, 1'b0);
    add_row("auipc_pc8", "auipc", 3, 0, 0, 1'b0);
    add_row("addi_rf", "addi", 4, 1, 0, 1'b0);
    // previous rd, then the one before it
    add_row("addi_fwd_ex", "addi", 5, 4, 0, 1'b0);
    add_row("xori_fwd_wb", "xori", 6, 4, 0, 1'b0);
    add_row("slti_neg", "slti", 7, 1, 0, 1'b1);
    add_row("ori", "ori", 8, 2, 0, 1'b0);
    add_row("andi", "andi", 9, 3, 0, 1'b0);
    add_row("add", "add", 10, 1, 2, 1'b0);
    add_row("sub_fwd_ex", "sub", 11, 10, 2, 1'b0);
    add_row("slt_neg_a", "slt", 12, 1, 2, 1'b0);
    add_row("slt_neg_b", "slt", 13, 2, 1, 1'b0);
    add_row("sll", "sll", 14, 2, 3, 1'b0);
    add_row("srl_neg", "srl", 15, 1, 3, 1'b0);
    add_row("sra_neg", "sra", 16, 1, 3, 1'b0);
    add_row("xor_both_fwd", "xor", 17, 15, 16, 1'b0);
    add_row("or", "or", 18, 17, 14, 1'b0);
    add_row("and", "and", 19, 18, 17, 1'b0);
    add_row("add_to_x0", "add", 0, 1, 2, 1'b0);
    add_row("read_x0", "add", 20, 0, 19, 1'b0);
    add_row("addi_from_x0", "addi", 21, 0, 0, 1'b0);
    add_row("sra_var", "sra", 22, 1, 21, 1'b0);
    add_row("sub_fwd", "sub", 23, 22, 21, 1'b0);
endtask

task automatic add_row(input string name, input string mnem, input int rd,
                       input int rs1, input int rs2, input bit neg);
    row_name.push_back(name);
    row_mnem.push_back(mnem);
    row_rd.push_back(rd);
    row_rs1.push_back(rs1);
    row_rs2.push_back(rs2);
    row_neg.push_back(neg);
endtask

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, op_op_imm};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opcode);
    return {imm, rd, opcode};
endfunction

function automatic logic [31:0] encode_row(input int i);
    string       m;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    m   = row_mnem[i];
    rd  = 5'(row_rd[i]);
    rs1 = 5'(row_rs1[i]);
    rs2 = 5'(row_rs2[i]);
    imm = row_imm[i];
    if (m == "lui") return enc_u(imm[19:0], rd, op_lui);
    else if (m == "auipc") return enc_u(imm[19:0], rd, op_auipc);
    else if (m == "addi") return enc_i(imm[11:0], rs1, f3_add, rd);
    else if (m == "slti") return enc_i(imm[11:0], rs1, f3_slt, rd);
    else if (m == "xori") return enc_i(imm[11:0], rs1, f3_xor, rd);
    else if (m == "ori") return enc_i(imm[11:0], rs1, f3_or, rd);
    else if (m == "andi") return enc_i(imm[11:0], rs1, f3_and, rd);
    else if (m == "add") return enc_r(f7_base, rs2, rs1, f3_add, rd);
    else if (m == "sub") return enc_r(f7_alt, rs2, rs1, f3_add, rd);
    else if (m == "sll") return enc_r(f7_base, rs2, rs1, f3_sll, rd);
    else if (m == "slt") return enc_r(f7_base, rs2, rs1, f3_slt, rd);
    else if (m == "xor") return enc_r(f7_base, rs2, rs1, f3_xor, rd);
    else if (m == "srl") return enc_r(f7_base, rs2, rs1, f3_sr, rd);
    else if (m == "sra") return enc_r(f7_alt, rs2, rs1, f3_sr, rd);
    else if (m == "or") return enc_r(f7_base, rs2, rs1, f3_or, rd);
    else if (m == "and") return enc_r(f7_base, rs2, rs1, f3_and, rd);
    return 32'h0;
endfunction

`endif

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
    import rv_isa_pkg::*, core_cfg_pkg::*;
();

    logic                       clock_1hz;
    logic                       KEY0;
    logic                       prog_we;
    logic [imem_addr_width-1:0] prog_addr;
    logic [xlen-1:0]            prog_data;
    logic [7:0]                 LEDG;
    logic                       LEDR0;
    logic                       LEDR9;
    logic                       wb_valid;
    logic [reg_addr_width-1:0]  wb_rd;
    logic [xlen-1:0]            wb_data;

    // stimulus table and derived values, one entry per row
    string       row_name[$];
    string       row_mnem[$];
    int          row_rd[$];
    int          row_rs1[$];
    int          row_rs2[$];
    bit          row_neg[$];
    logic [31:0] row_imm[$];
    logic [31:0] row_exp[$];

    logic [31:0] model_regs[32];
    logic [31:0] lfsr_state;
    logic [7:0]  exp_ledg;
    bit          table_ready;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    cpu_on_board dut0 (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .LEDG      (LEDG),
        .LEDR0     (LEDR0),
        .LEDR9     (LEDR9),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial begin
        clock_1hz = 1'b0;
        forever #2 clock_1hz = ~clock_1hz;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) return (state >> 1) ^ 32'h80200003;
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // arithmetic shift: logical shift, then refill the vacated top bits with the sign
    function automatic logic [31:0] sra_word(input logic [31:0] a, input logic [4:0] sh);
        logic [31:0] res;
        res = a >> sh;
        if (a[31]) res = res | ~(32'hffffffff >> sh);
        return res;
    endfunction

    function automatic logic [31:0] model_result(input string m, input logic [31:0] a,
                                                 input logic [31:0] b,
                                                 input logic [31:0] imm,
                                                 input logic [31:0] pc);
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        imm_i = {{20{imm[11]}}, imm[11:0]};
        imm_u = {imm[19:0], 12'h000};
        if (m == "lui") return imm_u;
        else if (m == "auipc") return pc + imm_u;
        else if (m == "addi") return a + imm_i;
        else if (m == "slti") return ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
        else if (m == "xori") return a ^ imm_i;
        else if (m == "ori") return a | imm_i;
        else if (m == "andi") return a & imm_i;
        else if (m == "add") return a + b;
        else if (m == "sub") return a - b;
        else if (m == "sll") return a << b[4:0];
        else if (m == "slt") return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (m == "xor") return a ^ b;
        else if (m == "srl") return a >> b[4:0];
        else if (m == "sra") return sra_word(a, b[4:0]);
        else if (m == "or") return a | b;
        else if (m == "and") return a & b;
        return 32'h0;
    endfunction

    // draws immediates, then runs the model over the table in program order
    task automatic prepare_program();
        string       m;
        logic [31:0] imm;
        logic [31:0] res;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        for (int i = 0; i < row_name.size(); i++) begin
            m   = row_mnem[i];
            imm = '0;
            if (m == "lui" || m == "auipc") begin
                imm = random_bits(20);
                if (row_neg[i]) imm[19] = 1'b1;
            end else if (m == "addi" || m == "slti" || m == "xori" || m == "ori" ||
                         m == "andi") begin
                imm = random_bits(12);
                if (row_neg[i]) imm[11] = 1'b1;
            end
            res = model_result(m, model_regs[row_rs1[i]], model_regs[row_rs2[i]], imm,
                               32'(4 * i));
            row_imm.push_back(imm);
            row_exp.push_back(res);
            if (row_rd[i] != 0) model_regs[row_rd[i]] = res;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s passed", name);
        end
    endtask

    initial begin
        int          n;
        int          k;
        int          errors_before;
        string       cur;
        logic [31:0] word;
        KEY0         = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_ledg     = '0;
        lfsr_state   = 32'h7bbb;
        build_table();
        prepare_program();
        n           = row_name.size();
        table_ready = 1'b1;

        // program, a nop filler, then an all-zero word that must trap
        for (int i = 0; i < n + 2; i++) begin
            if (i < n) word = encode_row(i);
            else if (i == n) word = enc_i(12'h000, 5'd0, f3_add, 5'd0);
            else word = 32'h0;
            @(negedge clock_1hz);
            prog_we   = 1'b1;
            prog_addr = imem_addr_width'(i);
            prog_data = swap_bytes(word);
        end
        @(negedge clock_1hz);
        prog_we = 1'b0;
        repeat (3) @(negedge clock_1hz);
        KEY0 = 1'b1;

        // row k reaches wb_* on edge k+3
        for (int e = 1; e <= n + 4; e++) begin
            @(negedge clock_1hz);
            k             = e - 3;
            errors_before = error_count;
            if (k >= 0 && k < n) cur = row_name[k];
            else if (k == n) cur = "filler_nop";
            else if (k == n + 1) cur = "illegal_word";
            else cur = "startup";
            check_value({cur, " LEDR0"}, 32'(e % 2), 32'(LEDR0));
            check_value({cur, " LEDR9"}, (e >= n + 4) ? 32'd1 : 32'd0, 32'(LEDR9));
            if (k >= 0 && k < n && row_rd[k] != 0) begin
                check_value({cur, " wb_valid"}, 32'd1, 32'(wb_valid));
                check_value({cur, " wb_rd"}, 32'(row_rd[k]), 32'(wb_rd));
                check_value({cur, " wb_data"}, row_exp[k], wb_data);
                exp_ledg = row_exp[k][7:0];
            end else begin
                check_value({cur, " wb_valid"}, 32'd0, 32'(wb_valid));
            end
            check_value({cur, " LEDG"}, 32'(exp_ledg), 32'(LEDG));
            if (k >= 0) finish_test(cur, errors_before);
        end

        $display("tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // loading and reset cycles, the table, and 20 cycles of slack
    initial begin
        int limit_cycles;
        wait (table_ready);
        limit_cycles = (row_name.size() + 6) + row_name.size() + 20;
        #(limit_cycles * 4);
        $display("writebacks stopped arriving before the time limit ran out");
        $display("Simulation FAILED");
        $finish;
    end

`include "cpu_tb_program.svh"

endmodule

`default_nettype wire

// File: src.f
+incdir+test
source/rv_isa_pkg.sv
source/core_cfg_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/cpu_on_board.sv
test/cpu_tb.sv
